// File: hdl/guard_types_pkg.sv
package guard_types_pkg;

    // tagged pointer layout, top down: reserved, mac, index, address
    localparam int PTR_W       = 64;
    localparam int ADDR_W      = 34;
    localparam int MAC_W       = 16;
    localparam int TAG_INDEX_W = 6;
    localparam int RSVD_W      = PTR_W - MAC_W - TAG_INDEX_W - ADDR_W;

    // burst length field, beats minus one
    localparam int LEN_W = 8;

    // one metadata entry per table slot
    localparam int ENTRY_W   = 128;
    localparam int LOWER_LSB = 0;
    localparam int VALID_BIT = 63;
    localparam int UPPER_LSB = 64;

    // a burst of len moves (len + 1) beats of this many bytes
    localparam int BEAT_BYTES = 32;

    // denial causes, in check priority
    localparam int CAUSE_W = 3;
    localparam logic [CAUSE_W-1:0] CAUSE_NONE    = 3'd0;
    localparam logic [CAUSE_W-1:0] CAUSE_INVALID = 3'd1;
    localparam logic [CAUSE_W-1:0] CAUSE_MAC     = 3'd2;
    localparam logic [CAUSE_W-1:0] CAUSE_LOWER   = 3'd3;
    localparam logic [CAUSE_W-1:0] CAUSE_UPPER   = 3'd4;

    // same 64-bit word seen raw or split into its tag fields
    typedef union packed {
        logic [PTR_W-1:0] raw;
        struct packed {
            logic [RSVD_W-1:0]      rsvd;
            logic [MAC_W-1:0]       mac;
            logic [TAG_INDEX_W-1:0] index;
            logic [ADDR_W-1:0]      addr;
        } tag;
    } guard_ptr_t;

endpackage

// File: hdl/ctrl_map_pkg.sv
package ctrl_map_pkg;

    localparam int CTRL_ADDR_W = 12;
    localparam int CTRL_DATA_W = 32;

    // secret key, written as four words
    localparam int KEY_WORDS = 4;
    localparam int KEY_W     = KEY_WORDS * CTRL_DATA_W;

    localparam logic [CTRL_ADDR_W-1:0] REG_KEY0 = 12'h000;
    localparam logic [CTRL_ADDR_W-1:0] REG_KEY1 = 12'h004;
    localparam logic [CTRL_ADDR_W-1:0] REG_KEY2 = 12'h008;
    localparam logic [CTRL_ADDR_W-1:0] REG_KEY3 = 12'h00C;

    // status: bit 0 pending, bits 3:1 cause
    localparam logic [CTRL_ADDR_W-1:0] REG_FAULT_STATUS = 12'h010;
    localparam logic [CTRL_ADDR_W-1:0] REG_FAULT_PTR_LO = 12'h014;
    localparam logic [CTRL_ADDR_W-1:0] REG_FAULT_PTR_HI = 12'h018;
    localparam int FAULT_CLEAR_BIT = 0;

    // entry i, word w at TABLE_BASE + 16*i + 4*w
    localparam logic [CTRL_ADDR_W-1:0] TABLE_BASE = 12'h800;

endpackage

// File: hdl/metadata_table.sv
module metadata_table #(
    parameter int INDEX_W = 6
) (
    input  logic                                     clk,

    // control side, one 32-bit lane at a time
    input  logic                                     tbl_wr,
    input  logic                                     tbl_rd,
    input  logic [INDEX_W-1:0]                       tbl_index,
    input  logic [1:0]                               tbl_word,
    input  logic [ctrl_map_pkg::CTRL_DATA_W-1:0]     tbl_wdata,
    output logic [ctrl_map_pkg::CTRL_DATA_W-1:0]     tbl_rdata,

    // guard side, whole entry
    input  logic                                     look_en,
    input  logic [INDEX_W-1:0]                       look_index,
    output logic [guard_types_pkg::ENTRY_W-1:0]      look_entry
);

    import guard_types_pkg::*;
    import ctrl_map_pkg::*;

    localparam int DEPTH = 1 << INDEX_W;

    logic [ENTRY_W-1:0] mem [DEPTH];

    // lane write and lane read, data one cycle after the strobe
    always_ff @(posedge clk) begin
        if (tbl_wr) begin
            mem[tbl_index][tbl_word*CTRL_DATA_W +: CTRL_DATA_W] <= tbl_wdata;
        end
        if (tbl_rd) begin
            tbl_rdata <= mem[tbl_index][tbl_word*CTRL_DATA_W +: CTRL_DATA_W];
        end
    end

    // output stays put while look_en is low
    always_ff @(posedge clk) begin
        if (look_en) begin
            look_entry <= mem[look_index];
        end
    end

endmodule

// File: hdl/guard_ctrl_regs.sv
module guard_ctrl_regs #(
    parameter int INDEX_W = 6
) (
    input  logic                                   data_clk,
    input  logic                                   rst,

    input  logic                                   ctrl_wr,
    input  logic                                   ctrl_rd,
    input  logic [ctrl_map_pkg::CTRL_ADDR_W-1:0]   ctrl_addr,
    input  logic [ctrl_map_pkg::CTRL_DATA_W-1:0]   ctrl_wdata,
    output logic [ctrl_map_pkg::CTRL_DATA_W-1:0]   ctrl_rdata,
    output logic                                   ctrl_rvalid,

    output logic [ctrl_map_pkg::KEY_W-1:0]         key,

    output logic                                   tbl_wr,
    output logic                                   tbl_rd,
    output logic [INDEX_W-1:0]                     tbl_index,
    output logic [1:0]                             tbl_word,
    output logic [ctrl_map_pkg::CTRL_DATA_W-1:0]   tbl_wdata,
    input  logic [ctrl_map_pkg::CTRL_DATA_W-1:0]   tbl_rdata,

    output logic                                   fault_clear,
    input  logic                                   fault_pending,
    input  logic [guard_types_pkg::CAUSE_W-1:0]    fault_cause,
    input  logic [guard_types_pkg::PTR_W-1:0]      fault_pointer
);

    import guard_types_pkg::*;
    import ctrl_map_pkg::*;

    // read-back sources
    localparam logic [2:0] SEL_NONE   = 3'd0;
    localparam logic [2:0] SEL_KEY    = 3'd1;
    localparam logic [2:0] SEL_STATUS = 3'd2;
    localparam logic [2:0] SEL_PTR_LO = 3'd3;
    localparam logic [2:0] SEL_PTR_HI = 3'd4;
    localparam logic [2:0] SEL_TABLE  = 3'd5;

    // 16 bytes per entry above the table base
    localparam int TABLE_END = int'(TABLE_BASE) + (16 << INDEX_W);

    logic [KEY_WORDS-1:0][CTRL_DATA_W-1:0] key_q;
    logic [$clog2(KEY_WORDS)-1:0]          rd_word_q;
    logic [2:0]                            rd_sel;
    logic [2:0]                            rd_sel_q;
    logic [CTRL_DATA_W-1:0]                status_word;
    logic                                  tbl_hit;

    assign tbl_hit = int'(ctrl_addr) >= int'(TABLE_BASE) && int'(ctrl_addr) < TABLE_END;

    assign tbl_wr    = ctrl_wr && tbl_hit;
    assign tbl_rd    = ctrl_rd && tbl_hit;
    assign tbl_index = ctrl_addr[4 +: INDEX_W];
    assign tbl_word  = ctrl_addr[3:2];
    assign tbl_wdata = ctrl_wdata;

    assign fault_clear = ctrl_wr && ctrl_addr == REG_FAULT_STATUS
                         && ctrl_wdata[FAULT_CLEAR_BIT];

    assign key = key_q;
    assign status_word = {{(CTRL_DATA_W-CAUSE_W-1){1'b0}}, fault_cause, fault_pending};

    always_ff @(posedge data_clk) begin
        if (rst) begin
            key_q <= '0;
        end else if (ctrl_wr) begin
            case (ctrl_addr)
                REG_KEY0: key_q[0] <= ctrl_wdata;
                REG_KEY1: key_q[1] <= ctrl_wdata;
                REG_KEY2: key_q[2] <= ctrl_wdata;
                REG_KEY3: key_q[3] <= ctrl_wdata;
                default: ;
            endcase
        end
    end

    always_comb begin
        case (ctrl_addr)
            REG_KEY0, REG_KEY1, REG_KEY2, REG_KEY3: rd_sel = SEL_KEY;
            REG_FAULT_STATUS: rd_sel = SEL_STATUS;
            REG_FAULT_PTR_LO: rd_sel = SEL_PTR_LO;
            REG_FAULT_PTR_HI: rd_sel = SEL_PTR_HI;
            default: rd_sel = tbl_hit ? SEL_TABLE : SEL_NONE;
        endcase
    end

    // remember the source, the data is picked a cycle later
    always_ff @(posedge data_clk) begin
        if (rst) begin
            ctrl_rvalid <= 1'b0;
            rd_sel_q    <= SEL_NONE;
        end else begin
            ctrl_rvalid <= ctrl_rd;
            if (ctrl_rd) begin
                rd_sel_q <= rd_sel;
            end
        end
    end

    always_ff @(posedge data_clk) begin
        if (ctrl_rd) begin
            rd_word_q <= ctrl_addr[3:2];
        end
    end

    always_comb begin
        case (rd_sel_q)
            SEL_KEY:    ctrl_rdata = key_q[rd_word_q];
            SEL_STATUS: ctrl_rdata = status_word;
            SEL_PTR_LO: ctrl_rdata = fault_pointer[CTRL_DATA_W-1:0];
            SEL_PTR_HI: ctrl_rdata = fault_pointer[PTR_W-1:CTRL_DATA_W];
            SEL_TABLE:  ctrl_rdata = tbl_rdata;
            default:    ctrl_rdata = '0;
        endcase
    end

endmodule

// File: hdl/guard_checker.sv
module guard_checker #(
    parameter int INDEX_W = 6
) (
    input  logic                                 data_clk,
    input  logic                                 rst,
    input  logic [ctrl_map_pkg::KEY_W-1:0]       key,

    input  logic                                 req_valid,
    input  logic                                 req_write,
    input  guard_types_pkg::guard_ptr_t          req_pointer,
    input  logic [guard_types_pkg::LEN_W-1:0]    req_len,
    output logic                                 req_ready,

    output logic                                 look_en,
    output logic [INDEX_W-1:0]                   look_index,
    input  logic [guard_types_pkg::ENTRY_W-1:0]  look_entry,

    output logic                                 fwd_valid,
    output logic                                 fwd_write,
    output logic [guard_types_pkg::ADDR_W-1:0]   fwd_addr,
    output logic [guard_types_pkg::LEN_W-1:0]    fwd_len,
    input  logic                                 fwd_ready,

    output logic                                 deny,
    output logic [guard_types_pkg::CAUSE_W-1:0]  deny_cause,
    output logic [guard_types_pkg::PTR_W-1:0]    deny_pointer
);

    import guard_types_pkg::*;
    import ctrl_map_pkg::*;

    // key slices, lower bound slices and index folded by xor
    function automatic logic [MAC_W-1:0] expected_mac(
        input logic [KEY_W-1:0]       k,
        input logic [ADDR_W-1:0]      lower_bound,
        input logic [TAG_INDEX_W-1:0] index
    );
        logic [3*MAC_W-1:0] lower_ext;
        logic [MAC_W-1:0]   mac;
        lower_ext = (3*MAC_W)'(lower_bound);
        mac = MAC_W'(index);
        for (int i = 0; i < KEY_W / MAC_W; i++) begin
            mac ^= k[i*MAC_W +: MAC_W];
        end
        for (int i = 0; i < 3; i++) begin
            mac ^= lower_ext[i*MAC_W +: MAC_W];
        end
        return mac;
    endfunction

    logic               ready_en;
    logic               a_valid;
    logic               a_looked;
    guard_ptr_t         a_ptr;
    logic               a_write;
    logic [LEN_W-1:0]   a_len;
    logic               accept;
    logic               a_move;
    logic [ADDR_W-1:0]  lower;
    logic [ADDR_W-1:0]  upper;
    logic [ADDR_W:0]    burst_last;
    logic               idx_ok;
    logic [CAUSE_W-1:0] cause;

    // stage A moves on once its entry is in and stage B is free
    assign a_move    = a_valid && a_looked && (!fwd_valid || fwd_ready);
    assign req_ready = ready_en && (!a_valid || a_move);
    assign accept    = req_valid && req_ready;

    // one table read per request, in its first cycle in stage A
    assign look_en    = a_valid && !a_looked;
    assign look_index = a_ptr.tag.index[INDEX_W-1:0];

    always_ff @(posedge data_clk) begin
        if (rst) begin
            ready_en <= 1'b0;
            a_valid  <= 1'b0;
            a_looked <= 1'b0;
        end else begin
            ready_en <= 1'b1;
            if (accept) begin
                a_valid <= 1'b1;
            end else if (a_move) begin
                a_valid <= 1'b0;
            end
            if (accept) begin
                a_looked <= 1'b0;
            end else if (look_en) begin
                a_looked <= 1'b1;
            end
        end
    end

    always_ff @(posedge data_clk) begin
        if (accept) begin
            a_ptr   <= req_pointer;
            a_write <= req_write;
            a_len   <= req_len;
        end
    end

    assign lower = look_entry[LOWER_LSB +: ADDR_W];
    assign upper = look_entry[UPPER_LSB +: ADDR_W];

    // index bits above INDEX_W have no entry behind them
    assign idx_ok = (a_ptr.tag.index >> INDEX_W) == '0;

    // last byte touched by the burst
    assign burst_last = (ADDR_W+1)'(a_ptr.tag.addr)
                        + ((ADDR_W+1)'(a_len) + 1'b1) * BEAT_BYTES - 1'b1;

    always_comb begin
        if (!look_entry[VALID_BIT] || !idx_ok) begin
            cause = CAUSE_INVALID;
        end else if (a_ptr.tag.mac != expected_mac(key, lower, a_ptr.tag.index)) begin
            cause = CAUSE_MAC;
        end else if (a_ptr.tag.addr < lower) begin
            cause = CAUSE_LOWER;
        end else if (burst_last > (ADDR_W+1)'(upper)) begin
            cause = CAUSE_UPPER;
        end else begin
            cause = CAUSE_NONE;
        end
    end

    // stage B: forward and hold, or a single deny pulse
    always_ff @(posedge data_clk) begin
        if (rst) begin
            fwd_valid <= 1'b0;
            deny      <= 1'b0;
        end else begin
            deny <= a_move && cause != CAUSE_NONE;
            if (a_move) begin
                fwd_valid <= cause == CAUSE_NONE;
            end else if (fwd_ready) begin
                fwd_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge data_clk) begin
        if (a_move) begin
            fwd_write    <= a_write;
            fwd_addr     <= a_ptr.tag.addr;
            fwd_len      <= a_len;
            deny_cause   <= cause;
            deny_pointer <= a_ptr.raw;
        end
    end

endmodule

// File: hdl/fault_log.sv
module fault_log (
    input  logic                                data_clk,
    input  logic                                rst,

    input  logic                                deny,
    input  logic [guard_types_pkg::CAUSE_W-1:0] deny_cause,
    input  logic [guard_types_pkg::PTR_W-1:0]   deny_pointer,

    input  logic                                fault_clear,
    output logic                                fault_pending,
    output logic [guard_types_pkg::CAUSE_W-1:0] fault_cause,
    output logic [guard_types_pkg::PTR_W-1:0]   fault_pointer,
    output logic                                interrupt
);

    logic capture;

    // only the first denial is kept
    // a clear arriving with a new denial lets the new one in
    assign capture = deny && (!fault_pending || fault_clear);

    always_ff @(posedge data_clk) begin
        if (rst) begin
            fault_pending <= 1'b0;
            fault_cause   <= '0;
        end else if (capture) begin
            fault_pending <= 1'b1;
            fault_cause   <= deny_cause;
        end else if (fault_clear) begin
            fault_pending <= 1'b0;
        end
    end

    always_ff @(posedge data_clk) begin
        if (capture) begin
            fault_pointer <= deny_pointer;
        end
    end

    // level interrupt for as long as a fault is pending
    assign interrupt = fault_pending;

endmodule

// File: hdl/dma_guard.sv
module dma_guard #(
    parameter int INDEX_W = 6
) (
    input  logic                                 data_clk,
    input  logic                                 rst,

    // control port
    input  logic                                 ctrl_wr,
    input  logic                                 ctrl_rd,
    input  logic [ctrl_map_pkg::CTRL_ADDR_W-1:0] ctrl_addr,
    input  logic [ctrl_map_pkg::CTRL_DATA_W-1:0] ctrl_wdata,
    output logic [ctrl_map_pkg::CTRL_DATA_W-1:0] ctrl_rdata,
    output logic                                 ctrl_rvalid,

    // incoming requests with tagged pointers
    input  logic                                 req_valid,
    input  logic                                 req_write,
    input  guard_types_pkg::guard_ptr_t          req_pointer,
    input  logic [guard_types_pkg::LEN_W-1:0]    req_len,
    output logic                                 req_ready,

    // checked requests with plain addresses
    output logic                                 fwd_valid,
    output logic                                 fwd_write,
    output logic [guard_types_pkg::ADDR_W-1:0]   fwd_addr,
    output logic [guard_types_pkg::LEN_W-1:0]    fwd_len,
    input  logic                                 fwd_ready,

    output logic                                 deny,
    output logic                                 interrupt
);

    import guard_types_pkg::*;
    import ctrl_map_pkg::*;

    logic [KEY_W-1:0]       key;
    logic                   tbl_wr;
    logic                   tbl_rd;
    logic [INDEX_W-1:0]     tbl_index;
    logic [1:0]             tbl_word;
    logic [CTRL_DATA_W-1:0] tbl_wdata;
    logic [CTRL_DATA_W-1:0] tbl_rdata;
    logic                   look_en;
    logic [INDEX_W-1:0]     look_index;
    logic [ENTRY_W-1:0]     look_entry;
    logic [CAUSE_W-1:0]     deny_cause;
    logic [PTR_W-1:0]       deny_pointer;
    logic                   fault_clear;
    logic                   fault_pending;
    logic [CAUSE_W-1:0]     fault_cause;
    logic [PTR_W-1:0]       fault_pointer;

    guard_ctrl_regs #(
        .INDEX_W(INDEX_W)
    ) ctrl_regs_i (
        .data_clk, .rst,
        .ctrl_wr, .ctrl_rd, .ctrl_addr, .ctrl_wdata, .ctrl_rdata, .ctrl_rvalid,
        .key,
        .tbl_wr, .tbl_rd, .tbl_index, .tbl_word, .tbl_wdata, .tbl_rdata,
        .fault_clear, .fault_pending, .fault_cause, .fault_pointer
    );

    metadata_table #(
        .INDEX_W(INDEX_W)
    ) table_i (
        .clk(data_clk),
        .tbl_wr, .tbl_rd, .tbl_index, .tbl_word, .tbl_wdata, .tbl_rdata,
        .look_en, .look_index, .look_entry
    );

    guard_checker #(
        .INDEX_W(INDEX_W)
    ) checker_i (
        .data_clk, .rst, .key,
        .req_valid, .req_write, .req_pointer, .req_len, .req_ready,
        .look_en, .look_index, .look_entry,
        .fwd_valid, .fwd_write, .fwd_addr, .fwd_len, .fwd_ready,
        .deny, .deny_cause, .deny_pointer
    );

    fault_log fault_log_i (
        .data_clk, .rst,
        .deny, .deny_cause, .deny_pointer,
        .fault_clear, .fault_pending, .fault_cause, .fault_pointer,
        .interrupt
    );

endmodule

// File: bench/tb_clock.sv
module tb_clock #(
    parameter int PERIOD_NS = 8
) (
    output logic clk
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
    end

    // free running, first rising edge after half a period
    always #(PERIOD_NS / 2) clk = ~clk;

endmodule

// File: bench/dma_guard_tb.sv
module dma_guard_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import guard_types_pkg::*;
    import ctrl_map_pkg::*;

    localparam int CLK_PERIOD      = 8;
    localparam int NUM_ROWS        = 14;
    localparam int WATCHDOG_CYCLES = 500 + 2 * NUM_ROWS * 200;

    // one request and its expected verdict
    typedef struct packed {
        logic [5:0]         index;
        logic               good_mac;
        logic [ADDR_W-1:0]  addr;
        logic [LEN_W-1:0]   len;
        logic               write;
        logic [CAUSE_W-1:0] verdict;
    } row_t;

    logic                   clk;
    logic                   rst;
    logic                   ctrl_wr;
    logic                   ctrl_rd;
    logic [CTRL_ADDR_W-1:0] ctrl_addr;
    logic [CTRL_DATA_W-1:0] ctrl_wdata;
    logic [CTRL_DATA_W-1:0] ctrl_rdata;
    logic                   ctrl_rvalid;
    logic                   req_valid;
    logic                   req_write;
    guard_ptr_t             req_pointer;
    logic [LEN_W-1:0]       req_len;
    logic                   req_ready;
    logic                   fwd_valid;
    logic                   fwd_write;
    logic [ADDR_W-1:0]      fwd_addr;
    logic [LEN_W-1:0]       fwd_len;
    logic                   fwd_ready;
    logic                   deny;
    logic                   interrupt;

    row_t              rows [NUM_ROWS];
    logic [ADDR_W-1:0] lower_bound [64];
    logic [ADDR_W-1:0] upper_bound [64];
    logic              entry_valid [64];
    int                entry_ids [4] = '{3, 17, 40, 63};
    logic [KEY_W-1:0]  key_val;
    int                expect_q [$];
    integer            seed = 32'h7c93;
    logic              stream_done;

    tb_clock #(.PERIOD_NS(CLK_PERIOD)) clock_i (.clk);

    dma_guard #(
        .INDEX_W(6)
    ) dma_guard_i (
        .data_clk(clk), .rst,
        .ctrl_wr, .ctrl_rd, .ctrl_addr, .ctrl_wdata, .ctrl_rdata, .ctrl_rvalid,
        .req_valid, .req_write, .req_pointer, .req_len, .req_ready,
        .fwd_valid, .fwd_write, .fwd_addr, .fwd_len, .fwd_ready,
        .deny, .interrupt
    );

    task automatic stop_with_failure(string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_equal(string name, logic [63:0] got, logic [63:0] exp);
        assert (got === exp) else begin
            stop_with_failure($sformatf("mismatch at %0t ns: %s got 0x%0h expected 0x%0h",
                                        $time, name, got, exp));
        end
    endtask

    task automatic load_stimulus();
        key_val = {32'h05f3_6d2b, 32'h7e19_c3a8, 32'hb4d2_0f61, 32'h3c5a_9e17};
        lower_bound[3]  = 34'h0_1000_0000;
        upper_bound[3]  = 34'h0_1000_ffff;
        entry_valid[3]  = 1'b1;
        lower_bound[17] = 34'h2_4000_0000;
        upper_bound[17] = 34'h2_4001_ffff;
        entry_valid[17] = 1'b1;
        lower_bound[40] = 34'h0_0000_1000;
        upper_bound[40] = 34'h0_0000_ffff;
        entry_valid[40] = 1'b0;
        lower_bound[63] = 34'h3_ffff_0000;
        upper_bound[63] = 34'h3_ffff_ffff;
        entry_valid[63] = 1'b1;
        // index, hash ok, address, len, write, verdict
        rows[0]  = '{6'd3,  1'b1, 34'h0_1000_0000, 8'd0,  1'b0, CAUSE_NONE};
        rows[1]  = '{6'd3,  1'b1, 34'h0_1000_0100, 8'd7,  1'b1, CAUSE_NONE};
        rows[2]  = '{6'd17, 1'b1, 34'h2_4000_0040, 8'd15, 1'b0, CAUSE_NONE};
        rows[3]  = '{6'd40, 1'b1, 34'h0_0000_1000, 8'd0,  1'b0, CAUSE_INVALID};
        rows[4]  = '{6'd3,  1'b0, 34'h0_1000_0000, 8'd0,  1'b1, CAUSE_MAC};
        rows[5]  = '{6'd3,  1'b1, 34'h0_0fff_ffe0, 8'd0,  1'b0, CAUSE_LOWER};
        rows[6]  = '{6'd3,  1'b1, 34'h0_1000_ffe0, 8'd1,  1'b0, CAUSE_UPPER};
        rows[7]  = '{6'd3,  1'b1, 34'h0_1000_ffe0, 8'd0,  1'b1, CAUSE_NONE};
        rows[8]  = '{6'd63, 1'b1, 34'h3_ffff_ffe0, 8'd0,  1'b0, CAUSE_NONE};
        rows[9]  = '{6'd63, 1'b1, 34'h3_ffff_ffe0, 8'd1,  1'b0, CAUSE_UPPER};
        rows[10] = '{6'd17, 1'b1, 34'h2_3fff_ffe0, 8'd0,  1'b1, CAUSE_LOWER};
        rows[11] = '{6'd17, 1'b1, 34'h2_4001_ff00, 8'd7,  1'b1, CAUSE_NONE};
        rows[12] = '{6'd40, 1'b0, 34'h0_0000_2000, 8'd0,  1'b0, CAUSE_INVALID};
        rows[13] = '{6'd3,  1'b0, 34'h0_0fff_0000, 8'd0,  1'b0, CAUSE_MAC};
    endtask

    // eight key slices, lower bound as 48 bits, then the index
    function automatic logic [15:0] tag_hash(logic [5:0] index, logic [ADDR_W-1:0] lower);
        logic [15:0] h;
        h = {10'd0, index};
        for (int s = 0; s < 8; s++) begin
            h = h ^ key_val[16*s +: 16];
        end
        h = h ^ lower[15:0] ^ lower[31:16] ^ {14'd0, lower[33:32]};
        return h;
    endfunction

    function automatic guard_ptr_t make_pointer(int r);
        guard_ptr_t  p;
        logic [15:0] mac;
        mac = tag_hash(rows[r].index, lower_bound[rows[r].index]);
        if (!rows[r].good_mac) begin
            mac = mac ^ 16'h0100;
        end
        p.raw       = '0;
        p.tag.mac   = mac;
        p.tag.index = rows[r].index;
        p.tag.addr  = rows[r].addr;
        return p;
    endfunction

    function automatic logic [31:0] entry_word(int idx, int w);
        logic [ENTRY_W-1:0] e;
        e = '0;
        e[LOWER_LSB +: ADDR_W] = lower_bound[idx];
        e[VALID_BIT]           = entry_valid[idx];
        e[UPPER_LSB +: ADDR_W] = upper_bound[idx];
        return e[32*w +: 32];
    endfunction

    function automatic logic [CTRL_ADDR_W-1:0] table_addr(int idx, int w);
        return TABLE_BASE + 12'(16 * idx + 4 * w);
    endfunction

    function automatic int first_deny_row();
        for (int r = 0; r < NUM_ROWS; r++) begin
            if (rows[r].verdict != CAUSE_NONE) begin
                return r;
            end
        end
        return 0;
    endfunction

    task automatic ctrl_write(logic [CTRL_ADDR_W-1:0] addr, logic [CTRL_DATA_W-1:0] data);
        ctrl_wr    = 1'b1;
        ctrl_addr  = addr;
        ctrl_wdata = data;
        @(posedge clk);
        #1;
        ctrl_wr = 1'b0;
    endtask

    task automatic read_check(logic [CTRL_ADDR_W-1:0] addr, logic [CTRL_DATA_W-1:0] exp);
        ctrl_rd   = 1'b1;
        ctrl_addr = addr;
        @(posedge clk);
        #1;
        ctrl_rd = 1'b0;
        assert (ctrl_rvalid) else begin
            stop_with_failure($sformatf("no read data one cycle after reading 0x%03h", addr));
        end
        check_equal($sformatf("ctrl_rdata[0x%03h]", addr), 64'(ctrl_rdata), 64'(exp));
        @(posedge clk);
        #1;
        assert (!ctrl_rvalid) else begin
            stop_with_failure("read data valid stayed high longer than one cycle");
        end
    endtask

    task automatic setup_tables();
        for (int w = 0; w < KEY_WORDS; w++) begin
            ctrl_write(REG_KEY0 + 12'(4 * w), key_val[32*w +: 32]);
        end
        foreach (entry_ids[e]) begin
            for (int w = 0; w < 4; w++) begin
                ctrl_write(table_addr(entry_ids[e], w), entry_word(entry_ids[e], w));
            end
        end
        for (int w = 0; w < KEY_WORDS; w++) begin
            read_check(REG_KEY0 + 12'(4 * w), key_val[32*w +: 32]);
        end
        foreach (entry_ids[e]) begin
            for (int w = 0; w < 4; w++) begin
                read_check(table_addr(entry_ids[e], w), entry_word(entry_ids[e], w));
            end
        end
        // unmapped space reads as zero
        read_check(12'h100, 32'd0);
    endtask

    // holds valid until a negedge sample shows ready
    task automatic send_request(int r);
        logic accepted;
        req_valid   = 1'b1;
        req_write   = rows[r].write;
        req_pointer = make_pointer(r);
        req_len     = rows[r].len;
        accepted    = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            accepted = req_ready;
            @(posedge clk);
            #1;
        end
        expect_q.push_back(r);
        req_valid = 1'b0;
    endtask

    task automatic wait_outputs_drained();
        while (expect_q.size() != 0) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic check_fault_record(int r);
        guard_ptr_t p;
        p = make_pointer(r);
        check_equal("interrupt", 64'(interrupt), 64'd1);
        read_check(REG_FAULT_STATUS, {28'd0, rows[r].verdict, 1'b1});
        read_check(REG_FAULT_PTR_LO, p.raw[31:0]);
        read_check(REG_FAULT_PTR_HI, p.raw[63:32]);
    endtask

    task automatic clear_fault();
        ctrl_write(REG_FAULT_STATUS, 32'd1);
        check_equal("interrupt", 64'(interrupt), 64'd0);
    endtask

    // one request alone, fwd_ready high, verdict two edges after accept
    task automatic run_single(int r);
        int   edges;
        logic seen;
        fwd_ready = 1'b1;
        send_request(r);
        edges = 0;
        seen  = 1'b0;
        while (!seen && edges < 8) begin
            @(posedge clk);
            #1;
            edges++;
            seen = fwd_valid || deny;
        end
        check_equal("response latency in cycles", 64'(edges), 64'd2);
        wait_outputs_drained();
        if (rows[r].verdict != CAUSE_NONE) begin
            check_fault_record(r);
            clear_fault();
        end
    endtask

    task automatic stream_rows();
        logic [31:0] rnd;
        stream_done = 1'b0;
        fork
            begin
                for (int r = 0; r < NUM_ROWS; r++) begin
                    send_request(r);
                end
                stream_done = 1'b1;
            end
            begin
                while (!stream_done) begin
                    rnd = $random(seed);
                    fwd_ready = rnd[0];
                    @(posedge clk);
                    #1;
                end
            end
        join
        fwd_ready = 1'b1;
        wait_outputs_drained();
        // later faults must not have replaced the first one
        check_fault_record(first_deny_row());
        clear_fault();
    endtask

    // every forward or deny matches the oldest accepted row
    always @(negedge clk) begin : output_monitor
        int r;
        if (!rst && (deny || (fwd_valid && fwd_ready))) begin
            assert (expect_q.size() != 0) else begin
                stop_with_failure("an output appeared with no request outstanding");
            end
            r = expect_q.pop_front();
            if (deny) begin
                assert (rows[r].verdict != CAUSE_NONE) else begin
                    stop_with_failure($sformatf("row %0d was denied but is legal", r));
                end
            end else begin
                assert (rows[r].verdict == CAUSE_NONE) else begin
                    stop_with_failure($sformatf("row %0d was forwarded but is illegal", r));
                end
                check_equal("fwd_addr", 64'(fwd_addr), 64'(rows[r].addr));
                check_equal("fwd_len", 64'(fwd_len), 64'(rows[r].len));
                check_equal("fwd_write", 64'(fwd_write), 64'(rows[r].write));
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        stop_with_failure($sformatf("timeout after %0d cycles", WATCHDOG_CYCLES));
    end

    initial begin : main
        rst         = 1'b1;
        ctrl_wr     = 1'b0;
        ctrl_rd     = 1'b0;
        ctrl_addr   = '0;
        ctrl_wdata  = '0;
        req_valid   = 1'b0;
        req_write   = 1'b0;
        req_pointer = '0;
        req_len     = '0;
        fwd_ready   = 1'b1;
        load_stimulus();
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        // first cycle out of reset
        check_equal("req_ready", 64'(req_ready), 64'd0);
        check_equal("fwd_valid", 64'(fwd_valid), 64'd0);
        check_equal("deny", 64'(deny), 64'd0);
        check_equal("interrupt", 64'(interrupt), 64'd0);
        check_equal("ctrl_rvalid", 64'(ctrl_rvalid), 64'd0);
        read_check(REG_KEY0, 32'd0);
        setup_tables();
        for (int r = 0; r < NUM_ROWS; r++) begin
            run_single(r);
        end
        stream_rows();
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// File: src.f
hdl/guard_types_pkg.sv
hdl/ctrl_map_pkg.sv
hdl/metadata_table.sv
hdl/guard_ctrl_regs.sv
hdl/guard_checker.sv
hdl/fault_log.sv
hdl/dma_guard.sv
bench/tb_clock.sv
bench/dma_guard_tb.sv

// File: Makefile
TOP = dma_guard_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --assert -f src.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

lint:
	verilator --lint-only --timing -f src.f --top-module dma_guard

clean:
	rm -rf obj_dir sim.log
